//--- Makefile
# Verilator build and run of the memory control subsystem testbench

VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
TOP        = cpuctrl_tb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LOG        = sim.log
RUN_FLAGS  = +verilator+error+limit+1000
FAIL_MSG   = tests failed
PASS_MSG   = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a verdict, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/cpuctrl_macros.svh
// fixed sizes and timing of the memory control subsystem
// no module takes parameters, so changing a value here resizes everything
`ifndef CPUCTRL_MACROS_SVH
`define CPUCTRL_MACROS_SVH

// --------------------------------------------------
// widths
// --------------------------------------------------
`define CPUCTRL_DATA_BITS      16
`define CPUCTRL_ADDR_BITS      16
// 256 words of system ram
`define CPUCTRL_RAM_ADDR_BITS  8
`define CPUCTRL_ROM_ADDR_BITS  4

// --------------------------------------------------
// boot copy and cpu access timing
// --------------------------------------------------
// whole rom image is copied
`define CPUCTRL_COPY_WORDS     16
// extra wait cycles after the read cycle
`define CPUCTRL_READ_CYCLES    1
// extra cycles the write strobe is held
`define CPUCTRL_WRITE_CYCLES   2
// full cpu address of the watched variable
`define CPUCTRL_WATCH_ADDR     16'h00ff

`endif

//--- logic/boot_copy.sv
// rom to ram copier, one word per clock while enabled
// copies the first CPUCTRL_COPY_WORDS rom words to the same ram indices, once
`timescale 1ns/1ps
`include "cpuctrl_macros.svh"

module boot_copy
	import cpuctrl_pkg::*;
(
	input  logic      clock,
	input  logic      reset,
	input  logic      enable,
	output rom_addr_t rom_addr,
	input  data_t     rom_data,
	output ram_req_t  ram_req,
	output logic      done
);

	// index of the last copied word
	localparam rom_addr_t last_word = rom_addr_t'(`CPUCTRL_COPY_WORDS - 1);

	rom_addr_t word_index;
	logic      copying;

	// --------------------------------------------------
	// word counter
	// --------------------------------------------------
	assign copying = enable && !done;

	always_ff @(posedge clock) begin
		if (reset) begin
			word_index <= '0;
			done <= 1'b0;
		end else if (copying) begin
			word_index <= word_index + 1'b1;
			// done follows the cycle of the last write and then sticks
			if (word_index == last_word)
				done <= 1'b1;
		end
	end

	// --------------------------------------------------
	// rom read and ram write
	// --------------------------------------------------
	assign rom_addr = word_index;

	always_comb begin
		ram_req.write = copying;
		// rom index zero-extended to the ram index
		ram_req.addr = ram_addr_t'(word_index);
		ram_req.wdata = rom_data;
	end

endmodule

//--- logic/boot_rom.sv
// program image rom, purely combinational
// word i holds 16'ha5a5 xor (i * 16'h0101)
`timescale 1ns/1ps

module boot_rom
	import cpuctrl_pkg::*;
(
	input  rom_addr_t addr,
	output data_t     data
);

	// image table, as a generated rom would look
	always_comb begin
		case (addr)
			4'h0: data = 16'ha5a5;
			4'h1: data = 16'ha4a4;
			4'h2: data = 16'ha7a7;
			4'h3: data = 16'ha6a6;
			4'h4: data = 16'ha1a1;
			4'h5: data = 16'ha0a0;
			4'h6: data = 16'ha3a3;
			4'h7: data = 16'ha2a2;
			4'h8: data = 16'hadad;
			4'h9: data = 16'hacac;
			4'ha: data = 16'hafaf;
			4'hb: data = 16'haeae;
			4'hc: data = 16'ha9a9;
			4'hd: data = 16'ha8a8;
			4'he: data = 16'habab;
			4'hf: data = 16'haaaa;
			// unreachable with a full 4-bit index
			default: data = 16'ha5a5;
		endcase
	end

endmodule

//--- logic/cpu_mem_port.sv
// cpu memory access fsm with read wait and write hold cycles
// only the low 8 address bits reach the ram, higher addresses alias modulo 256
`timescale 1ns/1ps
`include "cpuctrl_macros.svh"

module cpu_mem_port
	import cpuctrl_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     run,
	input  cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp,
	output ram_req_t ram_req,
	input  data_t    ram_rdata,
	output data_t    watch_data
);

	localparam logic [1 : 0] read_last = 2'(`CPUCTRL_READ_CYCLES);
	localparam logic [1 : 0] write_last = 2'(`CPUCTRL_WRITE_CYCLES);
	localparam addr_t watch_addr = addr_t'(`CPUCTRL_WATCH_ADDR);

	mem_access_t  state, next_state;
	logic [1 : 0] read_cycle, write_cycle;
	logic         read_done, write_done;
	data_t        write_data;

	assign read_done = (state == ACC_READ) && (read_cycle == read_last);
	assign write_done = (state == ACC_WRITE) && (write_cycle == write_last);

	// --------------------------------------------------
	// state, wait counters and watch register
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ACC_IDLE;
			read_cycle <= '0;
			write_cycle <= '0;
			watch_data <= '0;
		end else begin
			state <= next_state;

			// counters only run inside their own state
			if (state != ACC_READ || read_done)
				read_cycle <= '0;
			else
				read_cycle <= read_cycle + 1'b1;

			if (state != ACC_WRITE || write_done)
				write_cycle <= '0;
			else
				write_cycle <= write_cycle + 1'b1;

			// full 16-bit match, aliases of the watch word do not count
			if (state == ACC_PREPARE_WRITE && cpu_req.addr == watch_addr)
				watch_data <= cpu_req.wdata;
		end
	end

	// write word latched once, held through the write cycles
	always_ff @(posedge clock) begin
		if (state == ACC_PREPARE_WRITE)
			write_data <= cpu_req.wdata;
	end

	// --------------------------------------------------
	// access sequence
	// --------------------------------------------------
	always_comb begin
		next_state = state;

		case (state)
			ACC_IDLE: begin
				// requests wait here until the boot copy is over
				if (run && cpu_req.valid)
					next_state = cpu_req.write ? ACC_PREPARE_WRITE : ACC_READ;
			end

			// address out in the first cycle, data back in the next
			ACC_READ: begin
				if (read_done)
					next_state = ACC_IDLE;
			end

			ACC_PREPARE_WRITE: begin
				next_state = ACC_WRITE;
			end

			// after the hold, read back so rdata shows the stored word
			ACC_WRITE: begin
				if (write_done)
					next_state = ACC_READ;
			end

			default: begin
				next_state = ACC_IDLE;
			end
		endcase
	end

	// --------------------------------------------------
	// ram and cpu sides
	// --------------------------------------------------
	always_comb begin
		ram_req.write = (state == ACC_WRITE);
		ram_req.addr = cpu_req.addr[`CPUCTRL_RAM_ADDR_BITS - 1 : 0];
		ram_req.wdata = write_data;
	end

	// one-cycle ready with the registered ram word
	always_comb begin
		cpu_rsp.ready = read_done;
		cpu_rsp.rdata = ram_rdata;
	end

endmodule

//--- logic/cpuctrl_pkg.sv
// shared types of the memory control subsystem
// widths come from the macro header, so both must be compiled together
`include "cpuctrl_macros.svh"

package cpuctrl_pkg;

	// --------------------------------------------------
	// vectors
	// --------------------------------------------------
	typedef logic [`CPUCTRL_DATA_BITS - 1 : 0]     data_t;
	typedef logic [`CPUCTRL_ADDR_BITS - 1 : 0]     addr_t;
	typedef logic [`CPUCTRL_RAM_ADDR_BITS - 1 : 0] ram_addr_t;
	typedef logic [`CPUCTRL_ROM_ADDR_BITS - 1 : 0] rom_addr_t;

	// --------------------------------------------------
	// state machines
	// --------------------------------------------------
	// overall boot phase, owned by the arbiter
	typedef enum logic [1 : 0] {
		BOOT_RESET, BOOT_COPY, BOOT_RUN
	} boot_phase_t;

	// cpu memory access sequence
	typedef enum logic [1 : 0] {
		ACC_IDLE, ACC_READ, ACC_PREPARE_WRITE, ACC_WRITE
	} mem_access_t;

	// --------------------------------------------------
	// bundles
	// --------------------------------------------------
	// one ram port access, read when write is low
	typedef struct packed {
		logic      write;
		ram_addr_t addr;
		data_t     wdata;
	} ram_req_t;

	// cpu request, held until ready pulses
	typedef struct packed {
		logic  valid;
		logic  write;
		addr_t addr;
		data_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic  ready;
		data_t rdata;
	} cpu_rsp_t;

endpackage

//--- logic/cpuctrl_top.sv
// memory control subsystem top: boot rom copy, then cpu access to the ram
// the cpu must wait for run, requests before it are held until after the copy
`timescale 1ns/1ps

module cpuctrl_top
	import cpuctrl_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  cpu_req_t    cpu_req,
	output cpu_rsp_t    cpu_rsp,
	output logic        run,
	output boot_phase_t phase,
	output data_t       watch_data
);

	rom_addr_t rom_addr;
	data_t     rom_data;
	ram_req_t  copy_req;
	logic      copy_done;
	logic      copy_enable;
	ram_req_t  cpu_ram_req;
	ram_req_t  ram_req;
	data_t     ram_rdata;

	// --------------------------------------------------
	// boot path
	// --------------------------------------------------
	boot_rom boot_rom_i (
		.addr (rom_addr),
		.data (rom_data)
	);

	boot_copy boot_copy_i (
		.clock    (clock),
		.reset    (reset),
		.enable   (copy_enable),
		.rom_addr (rom_addr),
		.rom_data (rom_data),
		.ram_req  (copy_req),
		.done     (copy_done)
	);

	// --------------------------------------------------
	// ram and its owner
	// --------------------------------------------------
	ram_arbiter ram_arbiter_i (
		.clock       (clock),
		.reset       (reset),
		.copy_done   (copy_done),
		.copy_req    (copy_req),
		.cpu_ram_req (cpu_ram_req),
		.ram_req     (ram_req),
		.copy_enable (copy_enable),
		.run         (run),
		.phase       (phase)
	);

	sys_ram sys_ram_i (
		.clock (clock),
		.req   (ram_req),
		.rdata (ram_rdata)
	);

	// --------------------------------------------------
	// cpu side
	// --------------------------------------------------
	cpu_mem_port cpu_mem_port_i (
		.clock      (clock),
		.reset      (reset),
		.run        (run),
		.cpu_req    (cpu_req),
		.cpu_rsp    (cpu_rsp),
		.ram_req    (cpu_ram_req),
		.ram_rdata  (ram_rdata),
		.watch_data (watch_data)
	);

endmodule

//--- logic/ram_arbiter.sv
// boot phase fsm and ram port owner
// ram goes to the copier in BOOT_COPY and to the cpu port in BOOT_RUN, nothing else
`timescale 1ns/1ps

module ram_arbiter
	import cpuctrl_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        copy_done,
	input  ram_req_t    copy_req,
	input  ram_req_t    cpu_ram_req,
	output ram_req_t    ram_req,
	output logic        copy_enable,
	output logic        run,
	output boot_phase_t phase
);

	boot_phase_t next_phase;

	// --------------------------------------------------
	// boot phase fsm
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset)
			phase <= BOOT_RESET;
		else
			phase <= next_phase;
	end

	always_comb begin
		next_phase = phase;

		case (phase)
			// one cycle of settling before the copy starts
			BOOT_RESET: begin
				next_phase = BOOT_COPY;
			end

			BOOT_COPY: begin
				if (copy_done)
					next_phase = BOOT_RUN;
			end

			// run phase is final until the next reset
			BOOT_RUN: begin
				next_phase = BOOT_RUN;
			end

			default: begin
				next_phase = BOOT_RESET;
			end
		endcase
	end

	// --------------------------------------------------
	// master enables and port mux
	// --------------------------------------------------
	assign copy_enable = (phase == BOOT_COPY);
	assign run = (phase == BOOT_RUN);

	always_comb begin
		case (phase)
			BOOT_COPY: ram_req = copy_req;
			BOOT_RUN: ram_req = cpu_ram_req;
			// idle read of word 0, write strobe kept low
			default: ram_req = '0;
		endcase
	end

endmodule

//--- logic/sys_ram.sv
// single-port system ram, read data registered one cycle after the address
// a read of the address being written returns the old word
`timescale 1ns/1ps
`include "cpuctrl_macros.svh"

module sys_ram
	import cpuctrl_pkg::*;
(
	input  logic     clock,
	input  ram_req_t req,
	output data_t    rdata
);

	localparam int unsigned depth = 1 << `CPUCTRL_RAM_ADDR_BITS;

	// contents undefined until the boot copy or the cpu writes them
	data_t mem [depth];

	// --------------------------------------------------
	// write port
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		if (req.write)
			mem[req.addr] <= req.wdata;
	end

	// --------------------------------------------------
	// read port
	// --------------------------------------------------
	// reads every cycle, the cpu port picks the sample it needs
	always_ff @(posedge clock) begin
		rdata <= mem[req.addr];
	end

endmodule

//--- tb.f
+incdir+include
logic/cpuctrl_pkg.sv
logic/boot_rom.sv
logic/boot_copy.sv
logic/ram_arbiter.sv
logic/sys_ram.sv
logic/cpu_mem_port.sv
logic/cpuctrl_top.sv
testbench/clock_gen.sv
testbench/cpuctrl_assert.sv
testbench/cpuctrl_tb.sv

//--- testbench/clock_gen.sv
// 20 ns clock from time zero, reset high for the first 8 rising edges
// reset is released on a falling edge
`timescale 1ns/1ps

module clock_gen (
	output logic clock,
	output logic reset
);

	// half of the 20 ns period
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
	end

endmodule

//--- testbench/cpuctrl_assert.sv
// concurrent checks on the subsystem ports and the boot phase, bound into cpuctrl_top
// latency checks expect each request to be dropped right after its ready
`timescale 1ns/1ps
`include "cpuctrl_macros.svh"

module cpuctrl_assert
	import cpuctrl_pkg::*;
(
	input logic        clock,
	input logic        reset,
	input cpu_req_t    cpu_req,
	input cpu_rsp_t    cpu_rsp,
	input logic        run,
	input boot_phase_t phase,
	input data_t       watch_data,
	input ram_req_t    ram_req
);

	// failures so far, read by the testbench at the end
	int unsigned fail_count = 0;

	logic prev_valid;
	logic prev_run;
	logic request_start;

	// --------------------------------------------------
	// request start tracking
	// --------------------------------------------------
	always_ff @(posedge clock) begin
		prev_valid <= cpu_req.valid;
		prev_run <= run;
	end

	// new request, or one held since before run, meets an idle port
	assign request_start = run && cpu_req.valid && (!prev_valid || !prev_run);

	// --------------------------------------------------
	// reset and boot phase
	// --------------------------------------------------
	reset_quiet: assert property (@(posedge clock)
		reset |=> !run && !cpu_rsp.ready && watch_data == '0 && !ram_req.write)
		else begin fail_count++; $error("outputs or ram write active in reset"); end

	// copier owns the ram and writes from the first copy cycle
	copy_entry: assert property (@(posedge clock)
		$fell(reset) |=> phase == BOOT_COPY && ram_req.write)
		else begin fail_count++; $error("boot copy phase not entered"); end

	// 16 copy writes, done, then the phase change
	run_timing: assert property (@(posedge clock)
		$fell(reset) |-> ##18 $rose(run))
		else begin fail_count++; $error("run not raised 18 cycles after reset"); end

	run_sticky: assert property (@(posedge clock) disable iff (reset)
		run |=> run)
		else begin fail_count++; $error("run dropped"); end

	// --------------------------------------------------
	// cpu handshake
	// --------------------------------------------------
	ready_pulse: assert property (@(posedge clock) disable iff (reset)
		cpu_rsp.ready |=> !cpu_rsp.ready)
		else begin fail_count++; $error("ready wider than one cycle"); end

	ready_needs_run: assert property (@(posedge clock) disable iff (reset)
		!run |-> !cpu_rsp.ready)
		else begin fail_count++; $error("ready before run"); end

	read_latency: assert property (@(posedge clock) disable iff (reset)
		request_start && !cpu_req.write |->
			!cpu_rsp.ready ##1 !cpu_rsp.ready ##1 cpu_rsp.ready)
		else begin fail_count++; $error("read ready not 2 cycles after request"); end

	write_latency: assert property (@(posedge clock) disable iff (reset)
		request_start && cpu_req.write |->
			!cpu_rsp.ready ##1 !cpu_rsp.ready ##1 !cpu_rsp.ready ##1 !cpu_rsp.ready
			##1 !cpu_rsp.ready ##1 !cpu_rsp.ready ##1 cpu_rsp.ready)
		else begin fail_count++; $error("write ready not 6 cycles after request"); end

	// watch word moves only on a write to the full watch address
	watch_update: assert property (@(posedge clock) disable iff (reset)
		$changed(watch_data) |->
			$past(cpu_req.valid && cpu_req.write)
			&& $past(cpu_req.addr) == `CPUCTRL_WATCH_ADDR
			&& watch_data == $past(cpu_req.wdata))
		else begin fail_count++; $error("watch register changed unexpectedly"); end

endmodule

//--- testbench/cpuctrl_tb.sv
// testbench of the memory control subsystem, cpu requests change on falling edges
// ram model starts from the rom rule, words above 15 are only read after a write
`timescale 1ns/1ps
`include "cpuctrl_macros.svh"

module cpuctrl_tb
	import cpuctrl_pkg::*;
();

	localparam int ready_timeout = 64;
	localparam int wait_timeout = 40;

	logic        clock;
	logic        reset;
	cpu_req_t    cpu_req;
	cpu_rsp_t    cpu_rsp;
	logic        run;
	boot_phase_t phase;
	data_t       watch_data;

	data_t       ram_model [256];
	ram_addr_t   written [$];
	int unsigned checks;
	int unsigned errors;
	int unsigned timeouts;

	clock_gen clock_gen_i (
		.clock (clock),
		.reset (reset)
	);

	cpuctrl_top cpuctrl_top_i (
		.clock      (clock),
		.reset      (reset),
		.cpu_req    (cpu_req),
		.cpu_rsp    (cpu_rsp),
		.run        (run),
		.phase      (phase),
		.watch_data (watch_data)
	);

	bind cpuctrl_top cpuctrl_assert cpuctrl_assert_i (
		.clock       (clock),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_rsp     (cpu_rsp),
		.run         (run),
		.phase       (phase),
		.watch_data  (watch_data),
		.ram_req     (ram_req)
	);

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	// program word i of the boot image
	function automatic data_t rom_word(input int unsigned index);
		return 16'ha5a5 ^ data_t'(index * 16'h0101);
	endfunction

	task automatic compare_word(input string what, input data_t got, input data_t expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("ERROR %0t: %s got %h expected %h", $time, what, got, expected);
		end
	endtask

	task automatic finish_run();
		int unsigned assert_fails;
		assert_fails = cpuctrl_top_i.cpuctrl_assert_i.fail_count;
		$display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
			checks, errors, assert_fails, timeouts);
		if (errors == 0 && assert_fails == 0 && timeouts == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	// reset is sampled on rising edges, away from its falling-edge release
	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (reset !== 1'b0 && waited < wait_timeout) begin
			@(posedge clock);
			waited++;
		end
		if (reset !== 1'b0) begin
			timeouts++;
			$display("reset was never released");
		end
	endtask

	task automatic wait_for_run();
		int waited;
		waited = 0;
		while (!run && waited < wait_timeout) begin
			@(negedge clock);
			waited++;
		end
		if (!run) begin
			timeouts++;
			$display("run never rose after the boot copy");
		end
	endtask

	// one cpu access, request held until ready, dropped on the ready cycle
	task automatic cpu_access(input logic write, input addr_t addr, input data_t wdata,
		output data_t rdata);
		int   waited;
		logic got_ready;
		@(negedge clock);
		cpu_req.valid = 1'b1;
		cpu_req.write = write;
		cpu_req.addr = addr;
		cpu_req.wdata = wdata;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!cpu_rsp.ready && waited < ready_timeout);
		got_ready = cpu_rsp.ready;
		rdata = cpu_rsp.rdata;
		cpu_req = '0;
		if (!got_ready) begin
			timeouts++;
			$display("no ready within %0d cycles for address %h", ready_timeout, addr);
		end
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		data_t       rdata;
		data_t       wdata;
		addr_t       addr;
		ram_addr_t   index;

		cpu_req = '0;
		checks = 0;
		errors = 0;
		timeouts = 0;
		void'($urandom(32'h4db9));
		for (int i = 0; i < 256; i++)
			ram_model[i] = (i < 16) ? rom_word(i) : '0;

		// read raised during the boot copy, served only after run
		wait_reset_release();
		cpu_access(1'b0, 16'h0007, '0, rdata);
		compare_word("early read", rdata, ram_model[7]);
		compare_word("run at early ready", data_t'(run), 16'h0001);
		wait_for_run();
		compare_word("phase", data_t'(phase), data_t'(BOOT_RUN));

		// boot image
		for (int i = 0; i < 16; i++) begin
			cpu_access(1'b0, addr_t'(i), '0, rdata);
			compare_word("boot image", rdata, rom_word(i));
		end

		// random writes above the image, random upper byte
		repeat (24) begin
			index = ram_addr_t'(16 + $urandom % 239);
			addr = {8'($urandom), index};
			wdata = 16'($urandom);
			cpu_access(1'b1, addr, wdata, rdata);
			compare_word("write echo", rdata, wdata);
			ram_model[index] = wdata;
			written.push_back(index);
		end

		// read back through another alias of the same word
		foreach (written[k]) begin
			addr = {8'($urandom), written[k]};
			cpu_access(1'b0, addr, '0, rdata);
			compare_word("read back", rdata, ram_model[written[k]]);
		end
		compare_word("watch untouched", watch_data, '0);

		// alias of the watch word leaves the register alone
		wdata = 16'($urandom);
		cpu_access(1'b1, 16'h01ff, wdata, rdata);
		ram_model[8'hff] = wdata;
		compare_word("alias write echo", rdata, wdata);
		compare_word("watch after alias", watch_data, '0);
		cpu_access(1'b0, `CPUCTRL_WATCH_ADDR, '0, rdata);
		compare_word("alias read", rdata, ram_model[8'hff]);

		// the watch address itself
		wdata = 16'($urandom);
		cpu_access(1'b1, `CPUCTRL_WATCH_ADDR, wdata, rdata);
		ram_model[8'hff] = wdata;
		compare_word("watch write echo", rdata, wdata);
		compare_word("watch loaded", watch_data, wdata);

		cpu_access(1'b1, 16'h02ff, ~wdata, rdata);
		ram_model[8'hff] = ~wdata;
		compare_word("watch held", watch_data, wdata);
		cpu_access(1'b0, `CPUCTRL_WATCH_ADDR, '0, rdata);
		compare_word("watch word in ram", rdata, ram_model[8'hff]);

		finish_run();
	end

endmodule
